// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module icache_tb -f tb.f -o icache_sim
	./obj_dir/icache_sim | tee sim.log
	grep -q "Test OK" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== common/icache_config.svh ====
// ====================================================================
// icache geometry and AXI IDs
// ====================================================================
`ifndef ICACHE_CONFIG_SVH
`define ICACHE_CONFIG_SVH

// cache holds 2**(5+N) words
`define ICACHE_N            1

// line index and word offset
`define ICACHE_INDEX_BITS   (1 + `ICACHE_N)
`define ICACHE_OFFSET_BITS  4

// physical tag, whatever is left above the index
`define ICACHE_TAG_BITS     (32 - `ICACHE_INDEX_BITS - 6)

// AXI read IDs
`define ICACHE_ID_BITS      4
`define ICACHE_ID_CACHED    4'd1    // line fill
`define ICACHE_ID_UNCACHED  4'd2    // single word

`endif

// ==== common/icache_pkg.sv ====
// ====================================================================
// icache shared types
// ====================================================================
`include "icache_config.svh"

package icache_pkg;

    typedef logic [31:0] word_t;

    typedef logic [`ICACHE_INDEX_BITS-1:0]  index_t;
    typedef logic [`ICACHE_TAG_BITS-1:0]    tag_t;
    typedef logic [`ICACHE_OFFSET_BITS-1:0] offset_t;

    typedef struct packed {
        index_t  index;
        offset_t offset;   // word within line
    } ram_addr_t;

    // line-aligned when cached
    typedef struct packed {
        word_t addr;
        logic  cached;
    } refill_req_t;

    typedef struct packed {
        logic      en;
        ram_addr_t addr;
        word_t     data;
    } ram_wr_t;

    typedef struct packed {
        logic [`ICACHE_ID_BITS-1:0] id;
        word_t                      addr;
        logic [3:0]                 len;
    } axi_ar_t;

    typedef struct packed {
        logic [`ICACHE_ID_BITS-1:0] id;
        word_t                      data;
        logic [1:0]                 resp;
        logic                       last;
    } axi_r_t;

endpackage

// ==== design/icache_top.sv ====
// ====================================================================
// instruction cache top
// ====================================================================
`timescale 1ns/1ps

module icache_top (
    input  logic                 aclk,
    input  logic                 aresetn,
    output icache_pkg::axi_ar_t  ar,
    output logic                 arvalid,
    input  logic                 arready,
    input  icache_pkg::axi_r_t   r,
    input  logic                 rvalid,
    output logic                 rready,
    input  logic                 bus_en,
    input  icache_pkg::word_t    bus_addr,
    input  logic                 bus_cached,
    input  logic                 bus_stall,
    output icache_pkg::word_t    bus_rdata,
    output logic                 bus_streq
);
    import icache_pkg::*;

    logic        refill_start;
    refill_req_t refill_req;
    ram_wr_t     ram_wr;
    ram_addr_t   ram_rd_addr;
    word_t       ram_rd_data;
    word_t       uc_word;
    logic        uc_word_valid;
    logic        refill_done;

    icache_ctrl ctrl0 (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .bus_en        (bus_en),
        .bus_cached    (bus_cached),
        .bus_stall     (bus_stall),
        .bus_addr      (bus_addr),
        .bus_streq     (bus_streq),
        .bus_rdata     (bus_rdata),
        .ram_rd_addr   (ram_rd_addr),
        .ram_rd_data   (ram_rd_data),
        .refill_start  (refill_start),
        .refill_req    (refill_req),
        .uc_word       (uc_word),
        .uc_word_valid (uc_word_valid),
        .refill_done   (refill_done)
    );

    icache_refill refill0 (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .refill_start  (refill_start),
        .refill_req    (refill_req),
        .ar            (ar),
        .arvalid       (arvalid),
        .arready       (arready),
        .r             (r),
        .rvalid        (rvalid),
        .rready        (rready),
        .ram_wr        (ram_wr),
        .uc_word       (uc_word),
        .uc_word_valid (uc_word_valid),
        .refill_done   (refill_done)
    );

    icache_data_ram ram0 (
        .aclk    (aclk),
        .wr      (ram_wr),
        .rd_addr (ram_rd_addr),
        .rd_data (ram_rd_data)
    );

endmodule

// ==== icache/icache_ctrl.sv ====
// ====================================================================
// icache fetch lookup controller
// ====================================================================
`timescale 1ns/1ps
`include "icache_config.svh"

module icache_ctrl (
    input  logic                     aclk,
    input  logic                     aresetn,
    input  logic                     bus_en,
    input  logic                     bus_cached,
    input  logic                     bus_stall,
    input  icache_pkg::word_t        bus_addr,
    output logic                     bus_streq,
    output icache_pkg::word_t        bus_rdata,
    output icache_pkg::ram_addr_t    ram_rd_addr,
    input  icache_pkg::word_t        ram_rd_data,
    output logic                     refill_start,
    output icache_pkg::refill_req_t  refill_req,
    input  icache_pkg::word_t        uc_word,
    input  logic                     uc_word_valid,
    input  logic                     refill_done
);
    import icache_pkg::*;

    localparam int LINES    = 2 ** `ICACHE_INDEX_BITS;
    localparam int LINE_LSB = 2 + `ICACHE_OFFSET_BITS;

    typedef enum logic [1:0] {IDLE, REFILL, DONE} state_t;

    state_t           state;
    tag_t             tag_arr [LINES];
    logic [LINES-1:0] valid_arr;

    // one-word uncached buffer
    word_t uc_data;
    word_t uc_addr;
    logic  uc_valid;

    logic   rd_cached;     // source of the last served word
    index_t ad_index;
    tag_t   ad_tag;
    index_t fill_index;
    logic   ln_hit;
    logic   uc_hit;
    logic   ca_miss;

    assign ad_index   = bus_addr[LINE_LSB +: `ICACHE_INDEX_BITS];
    assign ad_tag     = bus_addr[31 -: `ICACHE_TAG_BITS];
    assign fill_index = refill_req.addr[LINE_LSB +: `ICACHE_INDEX_BITS];

    assign ln_hit = valid_arr[ad_index] && (tag_arr[ad_index] == ad_tag);
    assign uc_hit = uc_valid && (uc_addr == bus_addr);

    assign bus_streq = bus_en && (bus_cached ? !ln_hit : !uc_hit);
    assign ca_miss   = (state == IDLE) && bus_streq && bus_cached;

    assign ram_rd_addr = '{index: ad_index, offset: bus_addr[2 +: `ICACHE_OFFSET_BITS]};
    assign bus_rdata   = rd_cached ? ram_rd_data : uc_data;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state        <= IDLE;
            refill_start <= 1'b0;
            refill_req   <= '0;
            valid_arr    <= '0;
            uc_valid     <= 1'b0;
            rd_cached    <= 1'b0;
        end else begin
            refill_start <= 1'b0;
            if (bus_en && !bus_streq)
                rd_cached <= bus_cached;

            case (state)
                IDLE: begin
                    if (bus_streq) begin
                        state             <= REFILL;
                        refill_start      <= 1'b1;
                        refill_req.cached <= bus_cached;
                        if (bus_cached)
                            refill_req.addr <= {bus_addr[31:LINE_LSB], {LINE_LSB{1'b0}}};
                        else
                            refill_req.addr <= bus_addr;
                    end
                    if (ca_miss)
                        valid_arr[ad_index] <= 1'b0;  // tag is being replaced
                end
                REFILL: begin
                    if (uc_word_valid)
                        uc_valid <= 1'b1;
                    if (refill_done)
                        state <= DONE;
                end
                DONE: begin
                    if (refill_req.cached)
                        valid_arr[fill_index] <= 1'b1;
                    // wait until the fetch stage agrees
                    if (bus_stall == bus_streq) begin
                        state    <= IDLE;
                        uc_valid <= 1'b0;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (ca_miss)
            tag_arr[ad_index] <= ad_tag;
        if (uc_word_valid) begin
            uc_data <= uc_word;
            uc_addr <= refill_req.addr;
        end
    end

endmodule

// ==== icache/icache_data_ram.sv ====
// ====================================================================
// icache line data RAM
// ====================================================================
`timescale 1ns/1ps

module icache_data_ram (
    input  logic                   aclk,
    input  icache_pkg::ram_wr_t    wr,
    input  icache_pkg::ram_addr_t  rd_addr,
    output icache_pkg::word_t      rd_data
);
    import icache_pkg::*;

    localparam int DEPTH = 2 ** $bits(ram_addr_t);

    word_t mem [DEPTH];

    // read returns the old word on a same-address write
    always_ff @(posedge aclk) begin
        if (wr.en)
            mem[wr.addr] <= wr.data;
        rd_data <= mem[rd_addr];
    end

endmodule

// ==== icache/icache_refill.sv ====
// ====================================================================
// icache AXI refill engine
// ====================================================================
`timescale 1ns/1ps
`include "icache_config.svh"

module icache_refill (
    input  logic                     aclk,
    input  logic                     aresetn,
    input  logic                     refill_start,
    input  icache_pkg::refill_req_t  refill_req,
    output icache_pkg::axi_ar_t      ar,
    output logic                     arvalid,
    input  logic                     arready,
    input  icache_pkg::axi_r_t       r,
    input  logic                     rvalid,
    output logic                     rready,
    output icache_pkg::ram_wr_t      ram_wr,
    output icache_pkg::word_t        uc_word,
    output logic                     uc_word_valid,
    output logic                     refill_done
);
    import icache_pkg::*;

    localparam int LINE_LSB = 2 + `ICACHE_OFFSET_BITS;

    typedef enum logic [1:0] {R_IDLE, R_ADDR, R_DATA} state_t;

    state_t    state;
    logic      cached_q;
    offset_t   beat_cnt;
    logic      take;
    logic      wr_en;
    ram_addr_t wr_addr;
    word_t     wr_data;

    assign rready = 1'b1;   // never stall R

    // only beats of our own outstanding read
    assign take = (state == R_DATA) && rvalid && (r.id == ar.id);

    assign uc_word       = r.data;
    assign uc_word_valid = take && !cached_q;
    assign refill_done   = take && r.last;

    assign ram_wr = '{en: wr_en, addr: wr_addr, data: wr_data};

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state    <= R_IDLE;
            arvalid  <= 1'b0;
            cached_q <= 1'b0;
            beat_cnt <= '0;
            wr_en    <= 1'b0;
        end else begin
            wr_en <= 1'b0;
            case (state)
                R_IDLE: if (refill_start) begin
                    state    <= R_ADDR;
                    arvalid  <= 1'b1;
                    cached_q <= refill_req.cached;
                    beat_cnt <= '0;
                end
                R_ADDR: if (arready) begin
                    arvalid <= 1'b0;
                    state   <= R_DATA;
                end
                R_DATA: if (take) begin
                    if (cached_q) begin
                        wr_en    <= 1'b1;
                        beat_cnt <= beat_cnt + 1'b1;
                    end
                    if (r.last)
                        state <= R_IDLE;
                end
                default: state <= R_IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (state == R_IDLE && refill_start) begin
            ar.id   <= refill_req.cached ? `ICACHE_ID_CACHED : `ICACHE_ID_UNCACHED;
            ar.addr <= refill_req.addr;
            ar.len  <= refill_req.cached ? 4'd15 : 4'd0;   // 16 beats or one
        end
        if (take) begin
            wr_addr <= '{index: ar.addr[LINE_LSB +: `ICACHE_INDEX_BITS], offset: beat_cnt};
            wr_data <= r.data;
        end
    end

endmodule

// ==== tb.f ====
+incdir+common
common/icache_pkg.sv
icache/icache_data_ram.sv
icache/icache_refill.sv
icache/icache_ctrl.sv
design/icache_top.sv
testbench/icache_sva.sv
testbench/icache_tb.sv

// ==== testbench/icache_sva.sv ====
// ====================================================================
// icache AXI and fetch assertions
// ====================================================================
`timescale 1ns/1ps
`include "icache_config.svh"

module icache_sva (
    input logic                 aclk,
    input logic                 aresetn,
    input icache_pkg::axi_ar_t  ar,
    input logic                 arvalid,
    input logic                 arready,
    input logic                 bus_streq
);
    int fail_cnt = 0;

    // address phase held until accepted
    ar_stable: assert property (@(posedge aclk) disable iff (!aresetn)
        arvalid && !arready |=> arvalid && $stable(ar))
        else begin
            fail_cnt++;
            $error("AR channel changed before its handshake");
        end

    ar_reset: assert property (@(posedge aclk) !aresetn |-> !arvalid)
        else begin
            fail_cnt++;
            $error("arvalid high during reset");
        end

    // line fills are 16 beats and uncached reads one
    ar_len: assert property (@(posedge aclk) disable iff (!aresetn)
        arvalid |-> (ar.id == `ICACHE_ID_CACHED && ar.len == 4'd15) ||
                    (ar.id == `ICACHE_ID_UNCACHED && ar.len == 4'd0))
        else begin
            fail_cnt++;
            $error("AR burst length does not match its ID");
        end

    // a read address only follows a stalled fetch, two cycles back
    ar_after_miss: assert property (@(posedge aclk) disable iff (!aresetn)
        $rose(arvalid) |-> $past(bus_streq, 2))
        else begin
            fail_cnt++;
            $error("AR issued without a fetch miss");
        end

endmodule

bind icache_top icache_sva sva0 (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .ar        (ar),
    .arvalid   (arvalid),
    .arready   (arready),
    .bus_streq (bus_streq)
);

// ==== testbench/icache_tb.sv ====
// ====================================================================
// icache testbench
// ====================================================================
`timescale 1ns/1ps
`include "icache_config.svh"

module icache_tb;
    import icache_pkg::*;

    localparam int MAX_VEC  = 64;
    localparam int LINE_LSB = 2 + `ICACHE_OFFSET_BITS;
    localparam int LINES    = 2 ** `ICACHE_INDEX_BITS;

    logic    aclk;
    logic    aresetn;
    axi_ar_t ar;
    logic    arvalid;
    logic    arready;
    axi_r_t  r;
    logic    rvalid;
    logic    rready;
    logic    bus_en;
    word_t   bus_addr;
    logic    bus_cached;
    logic    bus_stall;
    word_t   bus_rdata;
    logic    bus_streq;

    word_t  vec_mem [3*MAX_VEC];    // address, cached, expected word
    int     n_vec;
    int     errors = 0;
    int     cycle_cnt = 0;
    int     cycle_limit = 1000;
    int     ar_cnt_cached = 0;
    int     ar_cnt_uncached = 0;
    word_t  ar_last_addr;
    integer seed = 32'h39d;

    // reference tag store
    logic [LINES-1:0] model_valid;
    tag_t             model_tag [LINES];

    icache_top dut0 (.*);

    initial aclk = 1'b0;
    always #20 aclk = ~aclk;

    task automatic check_equal(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    function automatic int idle_cycles();
        return $random(seed) & 3;
    endfunction

    // hold the fetch until the stall request drops
    task automatic fetch_word(input word_t addr, input logic cached, output word_t data);
        bus_en     = 1'b1;
        bus_addr   = addr;
        bus_cached = cached;
        bus_stall  = 1'b0;
        @(negedge aclk);
        while (bus_streq) begin
            bus_stall = 1'b1;
            @(negedge aclk);
        end
        bus_stall = 1'b0;
        @(negedge aclk);
        data = bus_rdata;
    endtask

    initial begin : axi_memory
        axi_ar_t req;
        arready = 1'b0;
        rvalid  = 1'b0;
        r       = '0;
        forever begin
            @(negedge aclk);
            if (arvalid) begin
                repeat (idle_cycles()) @(negedge aclk);
                arready = 1'b1;
                req     = ar;
                if (req.id == `ICACHE_ID_CACHED)
                    ar_cnt_cached++;
                else
                    ar_cnt_uncached++;
                ar_last_addr = req.addr;
                @(negedge aclk);
                arready = 1'b0;
                for (int i = 0; i <= int'(req.len); i++) begin
                    repeat (idle_cycles()) @(negedge aclk);
                    rvalid = 1'b1;
                    r = '{id: req.id, data: ~(req.addr + word_t'(4 * i)),
                          resp: 2'b00, last: (i == int'(req.len))};
                    check_equal("rready", rready, 1'b1);
                    @(negedge aclk);
                    rvalid = 1'b0;
                end
            end
        end
    end

    always @(posedge aclk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout: fetches did not finish within %0d cycles", cycle_limit);
            $display("Test FAILED");
            $finish;
        end
    end

    initial begin : stimulus
        word_t  addr;
        word_t  got;
        word_t  exp_ar_addr;
        logic   cached;
        logic   hit;
        index_t idx;
        tag_t   tg;
        int     exp_cached;
        int     exp_uncached;
        aresetn      = 1'b0;
        bus_en       = 1'b0;
        bus_addr     = '0;
        bus_cached   = 1'b0;
        bus_stall    = 1'b0;
        model_valid  = '0;
        exp_cached   = 0;
        exp_uncached = 0;
        exp_ar_addr  = '0;
        for (int i = 0; i < 3*MAX_VEC; i++)
            vec_mem[i] = '1;    // cached column above 1 marks the end
        $readmemh("testbench/icache_testdata.txt", vec_mem);
        n_vec = 0;
        while (n_vec < MAX_VEC && vec_mem[3*n_vec+1] <= 1)
            n_vec++;
        cycle_limit = n_vec * 120 + 20;
        if (n_vec == 0) begin
            errors++;
            $display("no fetch vectors were read from the test data file");
        end
        repeat (3) @(negedge aclk);
        aresetn = 1'b1;
        repeat (4) @(negedge aclk);
        check_equal("AR count before first fetch", ar_cnt_cached + ar_cnt_uncached, 0);

        for (int v = 0; v < n_vec; v++) begin
            addr   = vec_mem[3*v];
            cached = vec_mem[3*v+1][0];
            idx    = addr[LINE_LSB +: `ICACHE_INDEX_BITS];
            tg     = addr[31 -: `ICACHE_TAG_BITS];
            hit    = cached && model_valid[idx] && (model_tag[idx] == tg);
            if (cached && !hit) begin
                exp_cached++;
                model_valid[idx] = 1'b1;
                model_tag[idx]   = tg;
                exp_ar_addr      = {addr[31:LINE_LSB], {LINE_LSB{1'b0}}};
            end else if (!cached) begin
                exp_uncached++;
                exp_ar_addr = addr;
            end
            fetch_word(addr, cached, got);
            check_equal($sformatf("vector %0d word", v), got, vec_mem[3*v+2]);
            check_equal($sformatf("vector %0d line fills", v), ar_cnt_cached, exp_cached);
            check_equal($sformatf("vector %0d single reads", v), ar_cnt_uncached, exp_uncached);
            if (!hit)
                check_equal($sformatf("vector %0d AR address", v), ar_last_addr, exp_ar_addr);
        end

        bus_en = 1'b0;
        repeat (4) @(negedge aclk);
        $display("errors: %0d check, %0d assertion", errors, dut0.sva0.fail_cnt);
        if (errors == 0 && dut0.sva0.fail_cnt == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

// ==== testbench/icache_testdata.txt ====
// fetch vectors: address, cached flag, expected word
// expected word is the inverted address
00001004 1 ffffeffb
00001000 1 ffffefff
0000103c 1 ffffefc3
00001020 1 ffffefdf
20000010 0 dfffffef
20000014 0 dfffffeb
00002008 1 ffffdff7
00001008 1 ffffeff7
00002008 1 ffffdff7
00001044 1 ffffefbb
00001078 1 ffffef87
000010c0 1 ffffef3f
00001080 1 ffffef7f
00001000 1 ffffefff
20000014 0 dfffffeb
000010fc 1 ffffef03
00001004 1 ffffeffb
